/* source/apply_pkg.sv */
package apply_pkg;

	// Index holds the node id in the upper bits and the negate flag in bit 0
	localparam int INDEX_WIDTH = 16;
	localparam int NODE_ID_WIDTH = INDEX_WIDTH - 1;
	localparam int VAR_WIDTH = 8;

	typedef logic [INDEX_WIDTH-1:0] bdd_index_t;
	typedef logic [NODE_ID_WIDTH-1:0] node_id_t;
	typedef logic [VAR_WIDTH-1:0] bdd_var_t;
	typedef logic [2*INDEX_WIDTH-1:0] node_word_t; // {then child, else child}
	typedef logic [1:0] apply_op_t;

	localparam bdd_var_t VAR_TERMINAL = '1; // Variable of node 0
	localparam bdd_index_t BDD_FALSE = 0;
	localparam bdd_index_t BDD_TRUE = 1; // Terminal node with negate set

	localparam apply_op_t OP_AND = 2'd0;
	localparam apply_op_t OP_OR = 2'd1;
	localparam apply_op_t OP_XOR = 2'd2;

	typedef enum logic [2:0] {
		VF_IDLE,
		VF_SENT_F,
		VF_SENT_BOTH,
		VF_GOT_F_SEND_G,
		VF_WAIT_G,
		VF_DONE
	} var_fetch_state_t;

	typedef enum logic [2:0] {
		NF_IDLE,
		NF_SENT_F,
		NF_SENT_BOTH,
		NF_GOT_F_SEND_G,
		NF_WAIT_G,
		NF_DONE
	} node_fetch_state_t;

endpackage

/* source/stage_buffer.sv */
`timescale 1ns/100ps

module stage_buffer #(
	parameter int DATA_WIDTH = 8
) (
	input logic clk,
	input logic reset,
	input logic in_valid,
	input logic [DATA_WIDTH-1:0] in_data,
	output logic busy,
	output logic out_valid,
	output logic [DATA_WIDTH-1:0] out_data,
	input logic out_busy
);

	logic main_valid; // Item presented to the consumer
	logic [DATA_WIDTH-1:0] main_data;
	logic skid_valid; // Item taken while the consumer stalled
	logic [DATA_WIDTH-1:0] skid_data;
	logic take_in;
	logic take_out;

	assign take_in = in_valid & ~busy;
	assign take_out = main_valid & ~out_busy;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			main_valid <= 1'b0;
			skid_valid <= 1'b0;
		end
		else if (take_out)
		begin
			if (skid_valid)
				skid_valid <= 1'b0; // Skid entry moves up and main stays full
			else
				main_valid <= take_in;
		end
		else if (take_in)
		begin
			if (main_valid)
				skid_valid <= 1'b1;
			else
				main_valid <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (take_out & skid_valid)
			main_data <= skid_data;
		else if (take_in & (take_out | ~main_valid))
			main_data <= in_data;
		if (take_in & main_valid & ~take_out)
			skid_data <= in_data;
	end

	assign busy = skid_valid; // Full only when both entries hold an item
	assign out_valid = main_valid;
	assign out_data = main_data;

endmodule

/* source/apply_terminal_check.sv */
`timescale 1ns/100ps

module apply_terminal_check (
	input logic clk,
	input logic reset,
	input logic in_valid,
	input apply_pkg::apply_op_t in_op,
	input apply_pkg::bdd_index_t in_f,
	input apply_pkg::bdd_index_t in_g,
	output logic busy,
	output logic out_valid,
	input logic out_busy,
	output apply_pkg::apply_op_t out_op,
	output apply_pkg::bdd_index_t out_f,
	output apply_pkg::bdd_index_t out_g,
	output apply_pkg::bdd_index_t out_result,
	output logic out_hit
);

	localparam int DATA_WIDTH = $bits(apply_pkg::apply_op_t) + 3 * apply_pkg::INDEX_WIDTH + 1;

	logic hit;
	apply_pkg::bdd_index_t result;
	apply_pkg::bdd_index_t f_neg;
	apply_pkg::bdd_index_t g_neg;
	logic f_compl_g; // Same node with the opposite negate flag
	logic swap;
	logic [DATA_WIDTH-1:0] buf_in;
	logic [DATA_WIDTH-1:0] buf_out;

	assign f_neg = {in_f[apply_pkg::INDEX_WIDTH-1:1], ~in_f[0]};
	assign g_neg = {in_g[apply_pkg::INDEX_WIDTH-1:1], ~in_g[0]};
	assign f_compl_g = (in_f == g_neg);

	always_comb
	begin
		hit = 1'b1;
		result = apply_pkg::BDD_FALSE;
		case (in_op)
			apply_pkg::OP_AND:
			begin
				if (in_f == apply_pkg::BDD_FALSE || in_g == apply_pkg::BDD_FALSE)
					result = apply_pkg::BDD_FALSE;
				else if (in_f == apply_pkg::BDD_TRUE)
					result = in_g;
				else if (in_g == apply_pkg::BDD_TRUE)
					result = in_f;
				else if (in_f == in_g)
					result = in_f;
				else if (f_compl_g)
					result = apply_pkg::BDD_FALSE; // x & ~x
				else
					hit = 1'b0;
			end
			apply_pkg::OP_OR:
			begin
				if (in_f == apply_pkg::BDD_TRUE || in_g == apply_pkg::BDD_TRUE)
					result = apply_pkg::BDD_TRUE;
				else if (in_f == apply_pkg::BDD_FALSE)
					result = in_g;
				else if (in_g == apply_pkg::BDD_FALSE)
					result = in_f;
				else if (in_f == in_g)
					result = in_f;
				else if (f_compl_g)
					result = apply_pkg::BDD_TRUE;
				else
					hit = 1'b0;
			end
			apply_pkg::OP_XOR:
			begin
				if (in_f == apply_pkg::BDD_FALSE)
					result = in_g;
				else if (in_g == apply_pkg::BDD_FALSE)
					result = in_f;
				else if (in_f == apply_pkg::BDD_TRUE)
					result = g_neg;
				else if (in_g == apply_pkg::BDD_TRUE)
					result = f_neg;
				else if (in_f == in_g)
					result = apply_pkg::BDD_FALSE;
				else if (f_compl_g)
					result = apply_pkg::BDD_TRUE;
				else
					hit = 1'b0;
			end
			default: hit = 1'b0;
		endcase
	end

	// All kept operations commute so the operands are ordered with f <= g
	assign swap = ~hit & (in_f > in_g);
	assign buf_in = {in_op, swap ? in_g : in_f, swap ? in_f : in_g, result, hit};

	stage_buffer #(
		.DATA_WIDTH(DATA_WIDTH)
	) i_buffer (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_data(buf_in),
		.busy(busy),
		.out_valid(out_valid),
		.out_data(buf_out),
		.out_busy(out_busy)
	);

	assign {out_op, out_f, out_g, out_result, out_hit} = buf_out;

endmodule

/* source/apply_var_fetch.sv */
`timescale 1ns/100ps

module apply_var_fetch (
	input logic clk,
	input logic reset,
	input logic in_valid,
	output logic busy,
	input apply_pkg::apply_op_t in_op,
	input apply_pkg::bdd_index_t in_f,
	input apply_pkg::bdd_index_t in_g,
	input apply_pkg::bdd_index_t in_result,
	input logic in_hit,
	output logic var_req_valid,
	output apply_pkg::node_id_t var_req_id,
	input logic var_req_ready,
	input logic var_resp_valid,
	input apply_pkg::bdd_var_t var_resp_var,
	output logic out_valid,
	input logic out_busy,
	output apply_pkg::apply_op_t out_op,
	output apply_pkg::bdd_index_t out_f,
	output apply_pkg::bdd_index_t out_g,
	output apply_pkg::bdd_index_t out_result,
	output logic out_hit,
	output apply_pkg::bdd_var_t out_top,
	output logic out_fetch_f,
	output logic out_fetch_g
);

	apply_pkg::var_fetch_state_t state;
	apply_pkg::var_fetch_state_t next_state;
	logic held_valid;
	logic held_hit;
	apply_pkg::apply_op_t held_op;
	apply_pkg::bdd_index_t held_f;
	apply_pkg::bdd_index_t held_g;
	apply_pkg::bdd_index_t held_result;
	apply_pkg::bdd_var_t f_var;
	apply_pkg::bdd_var_t g_var;
	apply_pkg::bdd_var_t min_var;
	logic take_in;
	logic done;
	logic store_f;
	logic store_g;

	assign done = out_valid & ~out_busy;
	assign busy = held_valid & ~done; // Frees in the cycle the item leaves
	assign take_in = in_valid & ~busy;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			held_valid <= 1'b0;
			state <= apply_pkg::VF_IDLE;
		end
		else
		begin
			state <= next_state;
			if (take_in)
				held_valid <= 1'b1;
			else if (done)
				held_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (take_in)
		begin
			held_op <= in_op;
			held_f <= in_f;
			held_g <= in_g;
			held_result <= in_result;
			held_hit <= in_hit;
		end
		if (store_f)
			f_var <= var_resp_var;
		if (store_g)
			g_var <= var_resp_var;
	end

	always_comb
	begin
		next_state = state;
		var_req_valid = 1'b0;
		var_req_id = held_f[apply_pkg::INDEX_WIDTH-1:1];
		store_f = 1'b0;
		store_g = 1'b0;
		out_valid = 1'b0;
		case (state)
			apply_pkg::VF_IDLE:
			begin
				if (held_valid & held_hit)
					out_valid = 1'b1; // Terminal result needs no variables
				else if (held_valid)
				begin
					var_req_valid = 1'b1;
					if (var_req_ready)
						next_state = apply_pkg::VF_SENT_F;
				end
			end
			apply_pkg::VF_SENT_F:
			begin
				var_req_valid = 1'b1;
				var_req_id = held_g[apply_pkg::INDEX_WIDTH-1:1];
				store_f = var_resp_valid;
				if (var_resp_valid & var_req_ready)
					next_state = apply_pkg::VF_WAIT_G;
				else if (var_resp_valid)
					next_state = apply_pkg::VF_GOT_F_SEND_G;
				else if (var_req_ready)
					next_state = apply_pkg::VF_SENT_BOTH;
			end
			apply_pkg::VF_SENT_BOTH:
			begin
				store_f = var_resp_valid;
				if (var_resp_valid)
					next_state = apply_pkg::VF_WAIT_G;
			end
			apply_pkg::VF_GOT_F_SEND_G:
			begin
				var_req_valid = 1'b1;
				var_req_id = held_g[apply_pkg::INDEX_WIDTH-1:1];
				if (var_req_ready)
					next_state = apply_pkg::VF_WAIT_G;
			end
			apply_pkg::VF_WAIT_G:
			begin
				store_g = var_resp_valid; // Responses come back in request order
				if (var_resp_valid)
					next_state = apply_pkg::VF_DONE;
			end
			apply_pkg::VF_DONE:
			begin
				out_valid = 1'b1;
				if (!out_busy)
					next_state = apply_pkg::VF_IDLE;
			end
			default: next_state = apply_pkg::VF_IDLE;
		endcase
	end

	assign min_var = (f_var < g_var) ? f_var : g_var;
	assign out_top = held_hit ? apply_pkg::VAR_TERMINAL : min_var;
	assign out_fetch_f = ~held_hit & (f_var == min_var);
	assign out_fetch_g = ~held_hit & (g_var == min_var);

	assign out_op = held_op;
	assign out_f = held_f;
	assign out_g = held_g;
	assign out_result = held_result;
	assign out_hit = held_hit;

endmodule

/* source/apply_node_fetch.sv */
`timescale 1ns/100ps

module apply_node_fetch (
	input logic clk,
	input logic reset,
	input logic in_valid,
	output logic busy,
	input apply_pkg::apply_op_t in_op,
	input apply_pkg::bdd_index_t in_f,
	input apply_pkg::bdd_index_t in_g,
	input apply_pkg::bdd_index_t in_result,
	input logic in_hit,
	input apply_pkg::bdd_var_t in_top,
	input logic in_fetch_f,
	input logic in_fetch_g,
	output logic node_req_valid,
	output apply_pkg::node_id_t node_req_id,
	input logic node_req_ready,
	input logic node_resp_valid,
	input apply_pkg::node_word_t node_resp_word,
	output logic out_valid,
	output logic out_hit,
	output apply_pkg::bdd_index_t out_result,
	output apply_pkg::apply_op_t out_op,
	output apply_pkg::bdd_index_t out_f,
	output apply_pkg::bdd_index_t out_g,
	output apply_pkg::bdd_var_t out_top,
	output apply_pkg::bdd_index_t out_fn,
	output apply_pkg::bdd_index_t out_fnv,
	output apply_pkg::bdd_index_t out_gn,
	output apply_pkg::bdd_index_t out_gnv
);

	localparam int W = apply_pkg::INDEX_WIDTH;

	apply_pkg::node_fetch_state_t state;
	apply_pkg::node_fetch_state_t next_state;
	logic held_valid;
	logic held_hit;
	logic held_fetch_f;
	logic held_fetch_g;
	apply_pkg::apply_op_t held_op;
	apply_pkg::bdd_index_t held_f;
	apply_pkg::bdd_index_t held_g;
	apply_pkg::bdd_index_t held_result;
	apply_pkg::bdd_var_t held_top;
	apply_pkg::node_word_t f_word;
	apply_pkg::node_word_t g_word;
	apply_pkg::bdd_index_t f_flip;
	apply_pkg::bdd_index_t g_flip;
	logic use_f;
	logic use_g;
	logic take_in;
	logic store_f;
	logic store_g;

	assign use_f = held_fetch_f & ~held_hit;
	assign use_g = held_fetch_g & ~held_hit;
	assign busy = held_valid & ~out_valid; // Output never stalls
	assign take_in = in_valid & ~busy;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			held_valid <= 1'b0;
			state <= apply_pkg::NF_IDLE;
		end
		else
		begin
			state <= next_state;
			if (take_in)
				held_valid <= 1'b1;
			else if (out_valid)
				held_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (take_in)
		begin
			held_op <= in_op;
			held_f <= in_f;
			held_g <= in_g;
			held_result <= in_result;
			held_hit <= in_hit;
			held_top <= in_top;
			held_fetch_f <= in_fetch_f;
			held_fetch_g <= in_fetch_g;
		end
		if (store_f)
			f_word <= node_resp_word;
		if (store_g)
			g_word <= node_resp_word;
	end

	always_comb
	begin
		next_state = state;
		node_req_valid = 1'b0;
		node_req_id = held_f[W-1:1];
		store_f = 1'b0;
		store_g = 1'b0;
		out_valid = 1'b0;
		case (state)
			apply_pkg::NF_IDLE:
			begin
				if (held_valid & ~use_f & ~use_g)
					out_valid = 1'b1;
				else if (held_valid & use_f)
				begin
					node_req_valid = 1'b1;
					if (node_req_ready)
						next_state = apply_pkg::NF_SENT_F;
				end
				else if (held_valid)
				begin
					node_req_valid = 1'b1; // Only g sits at top
					node_req_id = held_g[W-1:1];
					if (node_req_ready)
						next_state = apply_pkg::NF_WAIT_G;
				end
			end
			apply_pkg::NF_SENT_F:
			begin
				node_req_valid = use_g;
				node_req_id = held_g[W-1:1];
				store_f = node_resp_valid;
				if (node_resp_valid & ~use_g)
					next_state = apply_pkg::NF_DONE;
				else if (node_resp_valid & node_req_ready)
					next_state = apply_pkg::NF_WAIT_G;
				else if (node_resp_valid)
					next_state = apply_pkg::NF_GOT_F_SEND_G;
				else if (use_g & node_req_ready)
					next_state = apply_pkg::NF_SENT_BOTH;
			end
			apply_pkg::NF_SENT_BOTH:
			begin
				store_f = node_resp_valid;
				if (node_resp_valid)
					next_state = apply_pkg::NF_WAIT_G;
			end
			apply_pkg::NF_GOT_F_SEND_G:
			begin
				node_req_valid = 1'b1;
				node_req_id = held_g[W-1:1];
				if (node_req_ready)
					next_state = apply_pkg::NF_WAIT_G;
			end
			apply_pkg::NF_WAIT_G:
			begin
				store_g = node_resp_valid;
				if (node_resp_valid)
					next_state = apply_pkg::NF_DONE;
			end
			apply_pkg::NF_DONE:
			begin
				out_valid = 1'b1;
				next_state = apply_pkg::NF_IDLE;
			end
			default: next_state = apply_pkg::NF_IDLE;
		endcase
	end

	// Negate flag of the operand carries into both children
	assign f_flip = {{(W-1){1'b0}}, held_f[0]};
	assign g_flip = {{(W-1){1'b0}}, held_g[0]};

	assign out_fn = use_f ? (f_word[2*W-1:W] ^ f_flip) : held_f;
	assign out_fnv = use_f ? (f_word[W-1:0] ^ f_flip) : held_f;
	assign out_gn = use_g ? (g_word[2*W-1:W] ^ g_flip) : held_g;
	assign out_gnv = use_g ? (g_word[W-1:0] ^ g_flip) : held_g;

	assign out_hit = held_hit;
	assign out_result = held_result;
	assign out_op = held_op;
	assign out_f = held_f;
	assign out_g = held_g;
	assign out_top = held_top;

endmodule

/* source/apply_front_end.sv */
`timescale 1ns/100ps

module apply_front_end (
	input logic clk,
	input logic reset,
	input logic in_valid,
	output logic busy,
	input apply_pkg::apply_op_t in_op,
	input apply_pkg::bdd_index_t in_f,
	input apply_pkg::bdd_index_t in_g,
	output logic var_req_valid,
	output apply_pkg::node_id_t var_req_id,
	input logic var_req_ready,
	input logic var_resp_valid,
	input apply_pkg::bdd_var_t var_resp_var,
	output logic node_req_valid,
	output apply_pkg::node_id_t node_req_id,
	input logic node_req_ready,
	input logic node_resp_valid,
	input apply_pkg::node_word_t node_resp_word,
	output logic out_valid,
	output logic out_hit,
	output apply_pkg::bdd_index_t out_result,
	output apply_pkg::apply_op_t out_op,
	output apply_pkg::bdd_index_t out_f,
	output apply_pkg::bdd_index_t out_g,
	output apply_pkg::bdd_var_t out_top,
	output apply_pkg::bdd_index_t out_fn,
	output apply_pkg::bdd_index_t out_fnv,
	output apply_pkg::bdd_index_t out_gn,
	output apply_pkg::bdd_index_t out_gnv
);

	// Terminal check to variable fetch
	logic tc_valid;
	logic vf_busy;
	apply_pkg::apply_op_t tc_op;
	apply_pkg::bdd_index_t tc_f;
	apply_pkg::bdd_index_t tc_g;
	apply_pkg::bdd_index_t tc_result;
	logic tc_hit;

	// Variable fetch to node fetch
	logic vf_valid;
	logic nf_busy;
	apply_pkg::apply_op_t vf_op;
	apply_pkg::bdd_index_t vf_f;
	apply_pkg::bdd_index_t vf_g;
	apply_pkg::bdd_index_t vf_result;
	logic vf_hit;
	apply_pkg::bdd_var_t vf_top;
	logic vf_fetch_f;
	logic vf_fetch_g;

	apply_terminal_check i_terminal_check (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_op(in_op),
		.in_f(in_f),
		.in_g(in_g),
		.busy(busy),
		.out_valid(tc_valid),
		.out_busy(vf_busy),
		.out_op(tc_op),
		.out_f(tc_f),
		.out_g(tc_g),
		.out_result(tc_result),
		.out_hit(tc_hit)
	);

	apply_var_fetch i_var_fetch (
		.clk(clk),
		.reset(reset),
		.in_valid(tc_valid),
		.busy(vf_busy),
		.in_op(tc_op),
		.in_f(tc_f),
		.in_g(tc_g),
		.in_result(tc_result),
		.in_hit(tc_hit),
		.var_req_valid(var_req_valid),
		.var_req_id(var_req_id),
		.var_req_ready(var_req_ready),
		.var_resp_valid(var_resp_valid),
		.var_resp_var(var_resp_var),
		.out_valid(vf_valid),
		.out_busy(nf_busy),
		.out_op(vf_op),
		.out_f(vf_f),
		.out_g(vf_g),
		.out_result(vf_result),
		.out_hit(vf_hit),
		.out_top(vf_top),
		.out_fetch_f(vf_fetch_f),
		.out_fetch_g(vf_fetch_g)
	);

	apply_node_fetch i_node_fetch (
		.clk(clk),
		.reset(reset),
		.in_valid(vf_valid),
		.busy(nf_busy),
		.in_op(vf_op),
		.in_f(vf_f),
		.in_g(vf_g),
		.in_result(vf_result),
		.in_hit(vf_hit),
		.in_top(vf_top),
		.in_fetch_f(vf_fetch_f),
		.in_fetch_g(vf_fetch_g),
		.node_req_valid(node_req_valid),
		.node_req_id(node_req_id),
		.node_req_ready(node_req_ready),
		.node_resp_valid(node_resp_valid),
		.node_resp_word(node_resp_word),
		.out_valid(out_valid),
		.out_hit(out_hit),
		.out_result(out_result),
		.out_op(out_op),
		.out_f(out_f),
		.out_g(out_g),
		.out_top(out_top),
		.out_fn(out_fn),
		.out_fnv(out_fnv),
		.out_gn(out_gn),
		.out_gnv(out_gnv)
	);

endmodule

/* testbench/tb_memory_model.sv */
`timescale 1ns/100ps

module tb_memory_model (
	input logic clk,
	input logic var_req_valid,
	input apply_pkg::node_id_t var_req_id,
	output logic var_req_ready,
	output logic var_resp_valid,
	output apply_pkg::bdd_var_t var_resp_var,
	input logic node_req_valid,
	input apply_pkg::node_id_t node_req_id,
	output logic node_req_ready,
	output logic node_resp_valid,
	output apply_pkg::node_word_t node_resp_word
);

	apply_pkg::bdd_var_t var_table [16];
	apply_pkg::node_word_t word_table [16]; // {then child, else child}
	apply_pkg::node_id_t var_id_q[$];
	int var_due_q[$]; // Cycle at which each queued answer may go out
	apply_pkg::node_id_t node_id_q[$];
	int node_due_q[$];
	int cycle;

	task automatic set_node(input logic [3:0] id, input apply_pkg::bdd_var_t v,
			input apply_pkg::bdd_index_t then_child, input apply_pkg::bdd_index_t else_child);
		var_table[id] = v;
		word_table[id] = {then_child, else_child};
	endtask

	initial
	begin
		var_req_ready = 1'b0;
		var_resp_valid = 1'b0;
		var_resp_var = '0;
		node_req_ready = 1'b0;
		node_resp_valid = 1'b0;
		node_resp_word = '0;
		cycle = 0;
		var_table = '{default: apply_pkg::VAR_TERMINAL};
		word_table = '{default: '0};
		// Index is {node id, negate} and node k shows up as 2k or 2k+1
		set_node(4'd1, 8'd7, 16'h0001, 16'h0000);
		set_node(4'd2, 8'd6, 16'h0001, 16'h0002);
		set_node(4'd3, 8'd5, 16'h0004, 16'h0003);
		set_node(4'd4, 8'd5, 16'h0002, 16'h0001);
		set_node(4'd5, 8'd4, 16'h0006, 16'h0008);
		set_node(4'd6, 8'd3, 16'h000a, 16'h0005);
		set_node(4'd7, 8'd3, 16'h0004, 16'h0007);
		set_node(4'd8, 8'd2, 16'h000c, 16'h000e);
		set_node(4'd9, 8'd2, 16'h0009, 16'h0002);
		set_node(4'd10, 8'd1, 16'h0010, 16'h0013);
		set_node(4'd11, 8'd0, 16'h0014, 16'h0012);
		set_node(4'd12, 8'd0, 16'h0001, 16'h0015);
		set_node(4'd13, 8'd7, 16'h0000, 16'h0001); // Higher id above a lower variable
		forever
		begin
			@(negedge clk);
			cycle++;

			// Oldest variable request is answered first and at most one per cycle
			var_resp_valid = 1'b0;
			if (var_id_q.size() > 0 && var_due_q[0] <= cycle)
			begin
				var_resp_valid = 1'b1;
				var_resp_var = var_table[var_id_q[0][3:0]];
				void'(var_id_q.pop_front());
				void'(var_due_q.pop_front());
			end
			var_req_ready = ($urandom_range(0, 3) != 0);
			if (var_req_valid === 1'b1 && var_req_ready) // Transfers at the next rising edge
			begin
				var_id_q.push_back(var_req_id);
				var_due_q.push_back(cycle + int'($urandom_range(1, 4)));
			end

			node_resp_valid = 1'b0;
			if (node_id_q.size() > 0 && node_due_q[0] <= cycle)
			begin
				node_resp_valid = 1'b1;
				node_resp_word = word_table[node_id_q[0][3:0]];
				void'(node_id_q.pop_front());
				void'(node_due_q.pop_front());
			end
			node_req_ready = ($urandom_range(0, 3) != 0);
			if (node_req_valid === 1'b1 && node_req_ready)
			begin
				node_id_q.push_back(node_req_id);
				node_due_q.push_back(cycle + int'($urandom_range(1, 4)));
			end
		end
	end

endmodule

/* testbench/tb_apply_front_end.sv */
`timescale 1ns/100ps

module tb_apply_front_end;

	localparam int TIMEOUT_CYCLES = 500;
	localparam int RANDOM_ITEMS = 40;

	typedef struct packed {
		logic hit;
		apply_pkg::bdd_index_t result;
		apply_pkg::apply_op_t op;
		apply_pkg::bdd_index_t f;
		apply_pkg::bdd_index_t g;
		apply_pkg::bdd_var_t top;
		apply_pkg::bdd_index_t fn;
		apply_pkg::bdd_index_t fnv;
		apply_pkg::bdd_index_t gn;
		apply_pkg::bdd_index_t gnv;
	} item_t;

	logic clk;
	logic reset;
	logic in_valid;
	logic busy;
	apply_pkg::apply_op_t in_op;
	apply_pkg::bdd_index_t in_f;
	apply_pkg::bdd_index_t in_g;
	logic var_req_valid;
	apply_pkg::node_id_t var_req_id;
	logic var_req_ready;
	logic var_resp_valid;
	apply_pkg::bdd_var_t var_resp_var;
	logic node_req_valid;
	apply_pkg::node_id_t node_req_id;
	logic node_req_ready;
	logic node_resp_valid;
	apply_pkg::node_word_t node_resp_word;
	logic out_valid;
	logic out_hit;
	apply_pkg::bdd_index_t out_result;
	apply_pkg::apply_op_t out_op;
	apply_pkg::bdd_index_t out_f;
	apply_pkg::bdd_index_t out_g;
	apply_pkg::bdd_var_t out_top;
	apply_pkg::bdd_index_t out_fn;
	apply_pkg::bdd_index_t out_fnv;
	apply_pkg::bdd_index_t out_gn;
	apply_pkg::bdd_index_t out_gnv;

	item_t rows[$]; // Stimulus with hand-derived hit and result
	item_t expected[$];
	item_t seen_q[$];
	item_t seen;

	apply_front_end i_dut (.*);

	tb_memory_model i_memory (.*);

	always #4 clk = ~clk;

	task automatic stop_run();
		$display("STATUS: FAIL");
		$fatal(1, "Run stopped at %0t", $time);
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expect_val);
		if (actual !== expect_val)
		begin
			$display("** Error: %s is 0x%0h, expected 0x%0h", name, actual, expect_val);
			stop_run();
		end
	endtask

	task automatic add_row(input apply_pkg::apply_op_t op, input apply_pkg::bdd_index_t f,
			input apply_pkg::bdd_index_t g, input logic hit, input apply_pkg::bdd_index_t result);
		item_t row;
		row = '0;
		row.op = op;
		row.f = f;
		row.g = g;
		row.hit = hit;
		row.result = result;
		rows.push_back(row);
	endtask

	// Two different non-terminal nodes never match a terminal rule
	function automatic item_t random_miss_row();
		item_t row;
		logic [3:0] f_id;
		logic [3:0] g_id;
		row = '0;
		row.op = apply_pkg::apply_op_t'($urandom_range(0, 2));
		f_id = 4'($urandom_range(1, 12));
		g_id = 4'($urandom_range(1, 11));
		if (g_id >= f_id)
			g_id = g_id + 4'd1;
		row.f = {11'd0, f_id, 1'($urandom_range(0, 1))};
		row.g = {11'd0, g_id, 1'($urandom_range(0, 1))};
		return row;
	endfunction

	// Reference model that takes ordering and cofactors from the node table
	function automatic item_t expect_item(input item_t row);
		item_t e;
		apply_pkg::bdd_var_t f_var;
		apply_pkg::bdd_var_t g_var;
		apply_pkg::node_word_t word;
		e = row;
		if (!row.hit && row.f > row.g)
		begin
			e.f = row.g;
			e.g = row.f;
		end
		e.top = apply_pkg::VAR_TERMINAL;
		e.fn = e.f;
		e.fnv = e.f;
		e.gn = e.g;
		e.gnv = e.g;
		if (!row.hit)
		begin
			f_var = i_memory.var_table[e.f[4:1]];
			g_var = i_memory.var_table[e.g[4:1]];
			e.top = (f_var < g_var) ? f_var : g_var;
			if (f_var == e.top)
			begin
				word = i_memory.word_table[e.f[4:1]];
				e.fn = word[31:16] ^ {15'd0, e.f[0]};
				e.fnv = word[15:0] ^ {15'd0, e.f[0]};
			end
			if (g_var == e.top)
			begin
				word = i_memory.word_table[e.g[4:1]];
				e.gn = word[31:16] ^ {15'd0, e.g[0]};
				e.gnv = word[15:0] ^ {15'd0, e.g[0]};
			end
		end
		return e;
	endfunction

	task automatic send_item(input item_t row);
		int waited;
		in_valid = 1'b1;
		in_op = row.op;
		in_f = row.f;
		in_g = row.g;
		waited = 0;
		while (busy)
		begin
			@(negedge clk);
			waited++;
			if (waited > TIMEOUT_CYCLES)
			begin
				$display("Timeout: input side stayed busy for %0d cycles", waited);
				stop_run();
			end
		end
		expected.push_back(expect_item(row));
		@(negedge clk); // Taken at the rising edge just passed
	endtask

	always @(negedge clk)
	begin
		if (!reset && out_valid === 1'b1)
		begin
			seen.hit = out_hit;
			seen.result = out_result;
			seen.op = out_op;
			seen.f = out_f;
			seen.g = out_g;
			seen.top = out_top;
			seen.fn = out_fn;
			seen.fnv = out_fnv;
			seen.gn = out_gn;
			seen.gnv = out_gnv;
			seen_q.push_back(seen);
		end
	end

	initial
	begin
		int waited;
		void'($urandom(32'h7c74_5858));
		clk = 1'b0;
		reset = 1'b1;
		in_valid = 1'b0;
		in_op = apply_pkg::OP_AND;
		in_f = '0;
		in_g = '0;
		repeat (10) @(negedge clk);
		reset = 1'b0;
		check_value("busy", 32'(busy), 32'd0);
		check_value("out_valid", 32'(out_valid), 32'd0);
		check_value("var_req_valid", 32'(var_req_valid), 32'd0);
		check_value("node_req_valid", 32'(node_req_valid), 32'd0);

		add_row(apply_pkg::OP_AND, 16'h0000, 16'h0006, 1'b1, 16'h0000);
		add_row(apply_pkg::OP_AND, 16'h0008, 16'h0000, 1'b1, 16'h0000);
		add_row(apply_pkg::OP_AND, 16'h0001, 16'h000a, 1'b1, 16'h000a);
		add_row(apply_pkg::OP_AND, 16'h000c, 16'h0001, 1'b1, 16'h000c);
		add_row(apply_pkg::OP_AND, 16'h0010, 16'h0010, 1'b1, 16'h0010);
		add_row(apply_pkg::OP_AND, 16'h0010, 16'h0011, 1'b1, 16'h0000); // x & ~x
		add_row(apply_pkg::OP_OR, 16'h0001, 16'h0006, 1'b1, 16'h0001);
		add_row(apply_pkg::OP_OR, 16'h0008, 16'h0001, 1'b1, 16'h0001);
		add_row(apply_pkg::OP_OR, 16'h0000, 16'h000a, 1'b1, 16'h000a);
		add_row(apply_pkg::OP_OR, 16'h000c, 16'h0000, 1'b1, 16'h000c);
		add_row(apply_pkg::OP_OR, 16'h0012, 16'h0012, 1'b1, 16'h0012);
		add_row(apply_pkg::OP_OR, 16'h0013, 16'h0012, 1'b1, 16'h0001);
		add_row(apply_pkg::OP_XOR, 16'h0000, 16'h0007, 1'b1, 16'h0007);
		add_row(apply_pkg::OP_XOR, 16'h0009, 16'h0000, 1'b1, 16'h0009);
		add_row(apply_pkg::OP_XOR, 16'h0001, 16'h0006, 1'b1, 16'h0007);
		add_row(apply_pkg::OP_XOR, 16'h000e, 16'h0001, 1'b1, 16'h000f);
		add_row(apply_pkg::OP_XOR, 16'h0014, 16'h0014, 1'b1, 16'h0000);
		add_row(apply_pkg::OP_XOR, 16'h0014, 16'h0015, 1'b1, 16'h0001);
		// Misses, swapped operands and the different fetch cases
		add_row(apply_pkg::OP_AND, 16'h0014, 16'h0006, 1'b0, 16'h0000);
		add_row(apply_pkg::OP_OR, 16'h0005, 16'h0015, 1'b0, 16'h0000);
		add_row(apply_pkg::OP_XOR, 16'h000b, 16'h0009, 1'b0, 16'h0000);
		add_row(apply_pkg::OP_AND, 16'h000c, 16'h000e, 1'b0, 16'h0000);
		add_row(apply_pkg::OP_OR, 16'h0011, 16'h0013, 1'b0, 16'h0000);
		add_row(apply_pkg::OP_XOR, 16'h0019, 16'h0016, 1'b0, 16'h0000);
		add_row(apply_pkg::OP_AND, 16'h0002, 16'h0018, 1'b0, 16'h0000);
		add_row(apply_pkg::OP_AND, 16'h001b, 16'h0009, 1'b0, 16'h0000); // Only f at top
		repeat (RANDOM_ITEMS) rows.push_back(random_miss_row());

		foreach (rows[i])
			send_item(rows[i]);
		in_valid = 1'b0;

		waited = 0;
		while (seen_q.size() < expected.size())
		begin
			@(negedge clk);
			waited++;
			if (waited > TIMEOUT_CYCLES)
			begin
				$display("Timeout: %0d of %0d items came out", seen_q.size(), expected.size());
				stop_run();
			end
		end
		repeat (20) @(negedge clk); // Room for a duplicate to show up
		check_value("out_valid count", 32'(seen_q.size()), 32'(expected.size()));

		foreach (expected[i])
		begin
			check_value("out_hit", 32'(seen_q[i].hit), 32'(expected[i].hit));
			if (expected[i].hit)
				check_value("out_result", 32'(seen_q[i].result), 32'(expected[i].result));
			check_value("out_op", 32'(seen_q[i].op), 32'(expected[i].op));
			check_value("out_f", 32'(seen_q[i].f), 32'(expected[i].f));
			check_value("out_g", 32'(seen_q[i].g), 32'(expected[i].g));
			check_value("out_top", 32'(seen_q[i].top), 32'(expected[i].top));
			check_value("out_fn", 32'(seen_q[i].fn), 32'(expected[i].fn));
			check_value("out_fnv", 32'(seen_q[i].fnv), 32'(expected[i].fnv));
			check_value("out_gn", 32'(seen_q[i].gn), 32'(expected[i].gn));
			check_value("out_gnv", 32'(seen_q[i].gnv), 32'(expected[i].gnv));
		end

		$display("STATUS: PASS");
		$finish;
	end

endmodule

/* vlog.f */
source/apply_pkg.sv
source/stage_buffer.sv
source/apply_terminal_check.sv
source/apply_var_fetch.sv
source/apply_node_fetch.sv
source/apply_front_end.sv
testbench/tb_memory_model.sv
testbench/tb_apply_front_end.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the apply front end testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_apply_front_end

verilator --binary --timing --timescale 1ns/100ps -f vlog.f \
	--top-module "$TOP" -Mdir obj_dir -o "$TOP"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi

if grep -qx "STATUS: PASS" "$LOG"; then
	exit 0
else
	echo "Pass line not found in $LOG"
	exit 1
fi
